//--- hw/clkmon_macros.svh
// Clock monitor parameters
`ifndef CLKMON_MACROS_SVH
`define CLKMON_MACROS_SVH

////////////////////////////////////////
// Channel setup
////////////////////////////////////////

// Number of monitored test clocks
`define CLKMON_NUM_CH 2

// Prescale factor is 2 to this power
`define CLKMON_PRESCALE_LG 4

// Width of a scaled count
`define CLKMON_COUNT_W 32

// Internal gate length in system cycles, short for simulation
`define CLKMON_GATE_CYCLES 2000

`endif

//--- hw/clkmon_pkg.sv
// Clock monitor types
`include "clkmon_macros.svh"

package clkmon_pkg;

	// Prescaler in the test clock domain
	typedef logic [`CLKMON_PRESCALE_LG-1:0] prescale_t;

	// Raw count of prescaled edges
	typedef logic [`CLKMON_COUNT_W-`CLKMON_PRESCALE_LG-1:0] edge_cnt_t;

	// Test clock cycles per gate, after scaling
	typedef logic [`CLKMON_COUNT_W-1:0] count_t;

	// Internal gate timer
	typedef logic [$clog2(`CLKMON_GATE_CYCLES)-1:0] gate_cnt_t;

	// Gate controller states
	typedef enum logic [1:0] {
		GATE_IDLE,
		GATE_ARM,
		GATE_RUN
	} gate_state_e;

	// Per-channel frequency window
	typedef struct packed {
		count_t min_count;
		count_t max_count;
	} ch_limits_t;

	// Per-channel result with sticky alarms
	typedef struct packed {
		count_t count;
		logic   alarm_low;
		logic   alarm_high;
	} ch_result_t;

endpackage

//--- hw/clkmon_gate_ctrl.sv
// Measurement gate controller
`include "clkmon_macros.svh"

module clkmon_gate_ctrl (
	input  logic i_sys_clk,
	input  logic i_reset,
	// Gate source select and external strobe
	input  logic i_ext_gate_en,
	input  logic i_ext_pps,
	// Capture done from channel 0
	input  logic i_count_done,
	output logic o_gate_tick,
	output logic o_meas_valid
);
	import clkmon_pkg::*;

	// Last timer value of an internal window
	localparam gate_cnt_t GATE_LAST = gate_cnt_t'(`CLKMON_GATE_CYCLES - 1);

	gate_state_e state_q;
	gate_cnt_t   timer_q;
	logic        ext_mode_q;
	logic        mode_chg;
	logic        tick_src;
	logic        full_win_q;

	// Mode select moved since last cycle
	assign mode_chg = (i_ext_gate_en != ext_mode_q);

	// External strobe or end of internal window
	assign tick_src = ext_mode_q ? i_ext_pps : (timer_q == GATE_LAST);

	////////////////////////////////////////
	// Internal window timer
	////////////////////////////////////////

	// Restarts on reset, mode change and wrap
	always_ff @(posedge i_sys_clk) begin
		if (i_reset || mode_chg || (state_q == GATE_IDLE) || (timer_q == GATE_LAST)) begin
			timer_q <= '0;
		end else begin
			timer_q <= timer_q + 1'b1;
		end
	end

	////////////////////////////////////////
	// Gate FSM
	////////////////////////////////////////

	always_ff @(posedge i_sys_clk) begin
		if (i_reset) begin
			state_q      <= GATE_IDLE;
			ext_mode_q   <= i_ext_gate_en;
			o_gate_tick  <= 1'b0;
			full_win_q   <= 1'b0;
			o_meas_valid <= 1'b0;
		end else if (mode_chg) begin
			// New source, so the next tick only opens a window
			state_q      <= GATE_ARM;
			ext_mode_q   <= i_ext_gate_en;
			o_gate_tick  <= 1'b0;
			full_win_q   <= 1'b0;
			o_meas_valid <= 1'b0;
		end else begin
			// Registered tick, one cycle after the strobe
			o_gate_tick <= tick_src && (state_q != GATE_IDLE);
			case (state_q)
				GATE_IDLE: state_q <= GATE_ARM;
				// First tick opens the first full window
				GATE_ARM: begin
					if (o_gate_tick) begin
						state_q <= GATE_RUN;
					end
				end
				// Any later tick closes a full window
				GATE_RUN: begin
					if (o_gate_tick) begin
						full_win_q <= 1'b1;
					end
				end
				default: state_q <= GATE_IDLE;
			endcase
			// Valid once a full window has been captured
			if (full_win_q && i_count_done) begin
				o_meas_valid <= 1'b1;
			end
		end
	end

endmodule

//--- hw/clkmon_edge_sampler.sv
// Test clock edge sampler
`include "clkmon_macros.svh"

module clkmon_edge_sampler (
	input  logic i_sys_clk,
	input  logic i_reset,
	// Clock under test, asynchronous
	input  logic i_tst_clk,
	// One pulse per prescaled test clock period
	output logic o_tst_edge
);
	import clkmon_pkg::*;

	// Free-running, no reset in the test clock domain
	prescale_t prescale_q = '0;

	// Synchronizer stages
	(* ASYNC_REG = "TRUE" *) logic sync_q1;
	(* ASYNC_REG = "TRUE" *) logic sync_q2;

	// Previous synchronized level
	logic level_q;

	////////////////////////////////////////
	// Test clock domain
	////////////////////////////////////////

	// Divides the test clock down by the prescale factor
	always_ff @(posedge i_tst_clk) begin
		prescale_q <= prescale_q + 1'b1;
	end

	////////////////////////////////////////
	// System clock domain
	////////////////////////////////////////

	// Top bit toggles slowly enough to cross with two flops
	always_ff @(posedge i_sys_clk) begin
		if (i_reset) begin
			sync_q1 <= 1'b0;
			sync_q2 <= 1'b0;
			level_q <= 1'b0;
		end else begin
			sync_q1 <= prescale_q[`CLKMON_PRESCALE_LG-1];
			sync_q2 <= sync_q1;
			level_q <= sync_q2;
		end
	end

	// Rising edge of the synchronized top bit
	assign o_tst_edge = sync_q2 && !level_q;

endmodule

//--- hw/clkmon_edge_counter.sv
// Gated edge counter
`include "clkmon_macros.svh"

module clkmon_edge_counter (
	input  logic                i_sys_clk,
	input  logic                i_reset,
	input  logic                i_tst_edge,
	input  logic                i_gate_tick,
	// Scaled count of the last window
	output clkmon_pkg::count_t  o_meas_count,
	output logic                o_count_done
);
	import clkmon_pkg::*;

	edge_cnt_t edge_cnt_q;
	logic      cnt_full;

	// Saturation point
	assign cnt_full = &edge_cnt_q;

	// Clears on the tick, so an edge on that cycle is dropped
	always_ff @(posedge i_sys_clk) begin
		if (i_reset || i_gate_tick) begin
			edge_cnt_q <= '0;
		end else if (i_tst_edge && !cnt_full) begin
			edge_cnt_q <= edge_cnt_q + 1'b1;
		end
	end

	////////////////////////////////////////
	// Capture and scale
	////////////////////////////////////////

	// Shift restores the prescale factor
	always_ff @(posedge i_sys_clk) begin
		if (i_reset) begin
			o_meas_count <= '0;
			o_count_done <= 1'b0;
		end else begin
			o_count_done <= i_gate_tick;
			if (i_gate_tick) begin
				o_meas_count <= {edge_cnt_q, {`CLKMON_PRESCALE_LG{1'b0}}};
			end
		end
	end

endmodule

//--- hw/clkmon_range_check.sv
// Frequency range checker
module clkmon_range_check (
	input  logic                   i_sys_clk,
	input  logic                   i_reset,
	// Count from the edge counter
	input  logic                   i_count_done,
	input  clkmon_pkg::count_t     i_meas_count,
	input  clkmon_pkg::ch_limits_t i_limits,
	// Clears both sticky alarms
	input  logic                   i_alarm_clear,
	output clkmon_pkg::ch_result_t o_result
);

	logic below_min;
	logic above_max;
	logic set_low;
	logic set_high;

	// Compare against the channel window
	assign below_min = (i_meas_count < i_limits.min_count);
	assign above_max = (i_meas_count > i_limits.max_count);

	// Only a fresh count can raise an alarm
	assign set_low  = i_count_done && below_min;
	assign set_high = i_count_done && above_max;

	////////////////////////////////////////
	// Result register
	////////////////////////////////////////

	always_ff @(posedge i_sys_clk) begin
		if (i_reset) begin
			o_result <= '0;
		end else begin
			if (i_count_done) begin
				o_result.count <= i_meas_count;
			end
			// Sticky, and a new set beats a clear
			o_result.alarm_low  <= set_low || (o_result.alarm_low && !i_alarm_clear);
			o_result.alarm_high <= set_high || (o_result.alarm_high && !i_alarm_clear);
		end
	end

endmodule

//--- hw/clkmon_top.sv
// Multi-channel clock monitor
`include "clkmon_macros.svh"

module clkmon_top (
	input  logic                                      i_sys_clk,
	input  logic                                      i_reset,
	// One clock per channel
	input  logic [`CLKMON_NUM_CH-1:0]                 i_tst_clk,
	// Gate source
	input  logic                                      i_ext_gate_en,
	input  logic                                      i_ext_pps,
	// Per-channel limits and results
	input  clkmon_pkg::ch_limits_t [`CLKMON_NUM_CH-1:0] i_limits,
	input  logic                                      i_alarm_clear,
	output clkmon_pkg::ch_result_t [`CLKMON_NUM_CH-1:0] o_results,
	output logic                                      o_meas_valid
);
	import clkmon_pkg::*;

	logic                      gate_tick;
	logic [`CLKMON_NUM_CH-1:0] tst_edge;
	logic [`CLKMON_NUM_CH-1:0] count_done;
	count_t                    meas_count [`CLKMON_NUM_CH];

	////////////////////////////////////////
	// Shared gate
	////////////////////////////////////////

	// Channel 0 paces the valid flag
	clkmon_gate_ctrl u_gate_ctrl (
		.i_sys_clk     (i_sys_clk),
		.i_reset       (i_reset),
		.i_ext_gate_en (i_ext_gate_en),
		.i_ext_pps     (i_ext_pps),
		.i_count_done  (count_done[0]),
		.o_gate_tick   (gate_tick),
		.o_meas_valid  (o_meas_valid)
	);

	////////////////////////////////////////
	// Channel datapaths
	////////////////////////////////////////

	for (genvar ch = 0; ch < `CLKMON_NUM_CH; ch++) begin : g_ch
		clkmon_edge_sampler u_sampler (
			.i_sys_clk  (i_sys_clk),
			.i_reset    (i_reset),
			.i_tst_clk  (i_tst_clk[ch]),
			.o_tst_edge (tst_edge[ch])
		);

		clkmon_edge_counter u_counter (
			.i_sys_clk    (i_sys_clk),
			.i_reset      (i_reset),
			.i_tst_edge   (tst_edge[ch]),
			.i_gate_tick  (gate_tick),
			.o_meas_count (meas_count[ch]),
			.o_count_done (count_done[ch])
		);

		clkmon_range_check u_check (
			.i_sys_clk     (i_sys_clk),
			.i_reset       (i_reset),
			.i_count_done  (count_done[ch]),
			.i_meas_count  (meas_count[ch]),
			.i_limits      (i_limits[ch]),
			.i_alarm_clear (i_alarm_clear),
			.o_result      (o_results[ch])
		);
	end

endmodule

//--- verification/clkmon_asserts.sv
// Clock monitor assertions
`include "clkmon_macros.svh"

module clkmon_asserts (
	input logic                                      i_sys_clk,
	input logic                                      i_reset,
	input logic                                      i_alarm_clear,
	input logic                                      i_gate_tick,
	input logic                                      i_meas_valid,
	input clkmon_pkg::ch_result_t [`CLKMON_NUM_CH-1:0] i_results
);

	// Gate tick is a single-cycle pulse
	a_tick_pulse: assert property (@(posedge i_sys_clk) disable iff (i_reset)
		i_gate_tick |=> !i_gate_tick)
		else $error("Gate tick high on two consecutive cycles");

	// No valid measurement while in reset
	a_valid_reset: assert property (@(posedge i_sys_clk) i_reset |=> !i_meas_valid)
		else $error("Measurement valid high during reset");

	// Alarms only fall through a clear or a reset
	for (genvar ch = 0; ch < `CLKMON_NUM_CH; ch++) begin : g_alarm
		a_low_sticky: assert property (@(posedge i_sys_clk) disable iff (i_reset)
			$fell(i_results[ch].alarm_low) |-> ($past(i_alarm_clear) || $past(i_reset)))
			else $error("Low alarm of channel %0d fell without a clear", ch);
		a_high_sticky: assert property (@(posedge i_sys_clk) disable iff (i_reset)
			$fell(i_results[ch].alarm_high) |-> ($past(i_alarm_clear) || $past(i_reset)))
			else $error("High alarm of channel %0d fell without a clear", ch);
	end

endmodule

bind clkmon_top clkmon_asserts u_asserts (
	.i_sys_clk     (i_sys_clk),
	.i_reset       (i_reset),
	.i_alarm_clear (i_alarm_clear),
	.i_gate_tick   (gate_tick),
	.i_meas_valid  (o_meas_valid),
	.i_results     (o_results)
);

//--- verification/clkmon_tb.sv
// Clock monitor testbench
`include "clkmon_macros.svh"

module clkmon_tb;
	import clkmon_pkg::*;

	localparam int SYS_PERIOD   = 40;
	localparam int TST0_PERIOD  = 14;
	localparam int TST1_PERIOD  = 26;
	localparam int RESET_CYCLES = 4;
	localparam int EXT_SPACING  = 1500;
	// Synchronizer phase plus the edge lost at the tick in scaled units
	localparam int TOL = 2 * (1 << `CLKMON_PRESCALE_LG);
	localparam logic [31:0] RAND_SEED = 32'heee0_b794;
	// Gate windows of all tests with external ones rounded up
	localparam int TEST_WINDOWS  = 12;
	localparam int WATCHDOG_TIME = 10 * TEST_WINDOWS * `CLKMON_GATE_CYCLES * SYS_PERIOD;

	logic                                i_sys_clk;
	logic                                i_reset;
	logic                                i_ext_gate_en;
	logic                                i_ext_pps;
	logic                                i_alarm_clear;
	ch_limits_t [`CLKMON_NUM_CH-1:0]     i_limits;
	ch_result_t [`CLKMON_NUM_CH-1:0]     o_results;
	logic                                o_meas_valid;

	// Test clocks and their run flags
	logic       tst_clk0;
	logic       tst_clk1;
	logic [1:0] tst_run;
	int         error_count = 0;

	clkmon_top uut (
		.i_sys_clk     (i_sys_clk),
		.i_reset       (i_reset),
		.i_tst_clk     ({tst_clk1, tst_clk0}),
		.i_ext_gate_en (i_ext_gate_en),
		.i_ext_pps     (i_ext_pps),
		.i_limits      (i_limits),
		.i_alarm_clear (i_alarm_clear),
		.o_results     (o_results),
		.o_meas_valid  (o_meas_valid)
	);

	////////////////////////////////////////
	// Clocks and watchdog
	////////////////////////////////////////

	always #(SYS_PERIOD / 2) i_sys_clk = ~i_sys_clk;

	// Test clocks freeze when their flag drops
	always begin
		#(TST0_PERIOD / 2);
		if (tst_run[0]) begin
			tst_clk0 = ~tst_clk0;
		end
	end

	always begin
		#(TST1_PERIOD / 2);
		if (tst_run[1]) begin
			tst_clk1 = ~tst_clk1;
		end
	end

	initial begin : watchdog
		#(WATCHDOG_TIME);
		$display("Timeout: tests did not finish within %0d time units", WATCHDOG_TIME);
		end_with_failure();
	end

	////////////////////////////////////////
	// Check helpers
	////////////////////////////////////////

	task automatic end_with_failure();
		$display("Done: errors found");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		error_count++;
		$display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp);
		end_with_failure();
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		assert (got === exp) else report_mismatch(name, {31'b0, got}, {31'b0, exp});
	endtask

	// Both alarms of every channel
	task automatic check_alarms(input logic exp_low, input logic exp_high);
		for (int ch = 0; ch < `CLKMON_NUM_CH; ch++) begin
			check_flag("o_results.alarm_low", o_results[ch].alarm_low, exp_low);
			check_flag("o_results.alarm_high", o_results[ch].alarm_high, exp_high);
		end
	endtask

	// Cycles of a test clock in a window of the given length
	function automatic int expected_count(input int ch, input int win_cycles);
		int period;
		period = (ch == 0) ? TST0_PERIOD : TST1_PERIOD;
		return win_cycles * SYS_PERIOD / period;
	endfunction

	task automatic check_count(input int ch, input int win_cycles);
		int exp_cnt;
		int got;
		exp_cnt = expected_count(ch, win_cycles);
		got = int'(o_results[ch].count);
		assert ((got >= exp_cnt - TOL) && (got <= exp_cnt + TOL)) else begin
			error_count++;
			$display("MISMATCH o_results[%0d].count: got 0x%08h, expected 0x%08h +/- 0x%0h",
				ch, got, exp_cnt, TOL);
			end_with_failure();
		end
	endtask

	task automatic set_limits(input int ch, input int lo, input int hi);
		i_limits[ch].min_count = count_t'(lo);
		i_limits[ch].max_count = count_t'(hi);
	endtask

	task automatic set_wide_limits();
		for (int ch = 0; ch < `CLKMON_NUM_CH; ch++) begin
			i_limits[ch].min_count = '0;
			i_limits[ch].max_count = '1;
		end
	endtask

	// Next gate tick plus capture and result update
	task automatic wait_window();
		@(posedge uut.gate_tick);
		repeat (3) @(negedge i_sys_clk);
	endtask

	task automatic wait_valid();
		do begin
			@(negedge i_sys_clk);
		end while (!o_meas_valid);
	endtask

	task automatic pulse_alarm_clear();
		i_alarm_clear = 1'b1;
		@(negedge i_sys_clk);
		i_alarm_clear = 1'b0;
	endtask

	task automatic pulse_pps();
		i_ext_pps = 1'b1;
		@(negedge i_sys_clk);
		i_ext_pps = 1'b0;
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic test_reset_state();
		check_flag("o_meas_valid", o_meas_valid, 1'b0);
		for (int ch = 0; ch < `CLKMON_NUM_CH; ch++) begin
			assert (o_results[ch].count == '0) else
				report_mismatch("o_results.count", o_results[ch].count, '0);
			check_flag("o_results.alarm_low", o_results[ch].alarm_low, 1'b0);
			check_flag("o_results.alarm_high", o_results[ch].alarm_high, 1'b0);
		end
		// First tick only opens a window
		wait_window();
		check_flag("o_meas_valid", o_meas_valid, 1'b0);
	endtask

	task automatic test_internal_count();
		wait_valid();
		check_count(0, `CLKMON_GATE_CYCLES);
		check_count(1, `CLKMON_GATE_CYCLES);
	endtask

	task automatic test_limit_alarms();
		int margin;
		int exp_cnt;
		margin = int'($urandom % 256);
		for (int ch = 0; ch < `CLKMON_NUM_CH; ch++) begin
			exp_cnt = expected_count(ch, `CLKMON_GATE_CYCLES);
			set_limits(ch, exp_cnt - TOL - margin, exp_cnt + TOL + margin);
		end
		wait_window();
		check_alarms(1'b0, 1'b0);
		// Window moved above the real frequency
		for (int ch = 0; ch < `CLKMON_NUM_CH; ch++) begin
			exp_cnt = expected_count(ch, `CLKMON_GATE_CYCLES);
			set_limits(ch, exp_cnt + 4 * TOL, exp_cnt + 8 * TOL);
		end
		wait_window();
		check_alarms(1'b1, 1'b0);
		set_wide_limits();
		wait_window();
		check_alarms(1'b1, 1'b0);
		pulse_alarm_clear();
		check_alarms(1'b0, 1'b0);
		// Window moved below the real frequency
		for (int ch = 0; ch < `CLKMON_NUM_CH; ch++) begin
			exp_cnt = expected_count(ch, `CLKMON_GATE_CYCLES);
			set_limits(ch, exp_cnt - 8 * TOL, exp_cnt - 4 * TOL);
		end
		wait_window();
		check_alarms(1'b0, 1'b1);
		set_wide_limits();
		pulse_alarm_clear();
		check_alarms(1'b0, 1'b0);
	endtask

	task automatic test_external_gate();
		i_ext_gate_en = 1'b1;
		@(negedge i_sys_clk);
		check_flag("o_meas_valid", o_meas_valid, 1'b0);
		pulse_pps();
		repeat (EXT_SPACING - 1) @(negedge i_sys_clk);
		check_flag("o_meas_valid", o_meas_valid, 1'b0);
		pulse_pps();
		repeat (EXT_SPACING - 1) @(negedge i_sys_clk);
		pulse_pps();
		repeat (3) @(negedge i_sys_clk);
		check_flag("o_meas_valid", o_meas_valid, 1'b1);
		check_count(0, EXT_SPACING);
		check_count(1, EXT_SPACING);
	endtask

	task automatic test_stopped_clock();
		for (int ch = 0; ch < `CLKMON_NUM_CH; ch++) begin
			set_limits(ch, expected_count(ch, `CLKMON_GATE_CYCLES) - TOL,
				expected_count(ch, `CLKMON_GATE_CYCLES) + TOL);
		end
		tst_run[1] = 1'b0;
		i_ext_gate_en = 1'b0;
		@(negedge i_sys_clk);
		check_flag("o_meas_valid", o_meas_valid, 1'b0);
		wait_valid();
		assert (o_results[1].count == '0) else
			report_mismatch("o_results[1].count", o_results[1].count, '0);
		check_flag("o_results[1].alarm_low", o_results[1].alarm_low, 1'b1);
		check_count(0, `CLKMON_GATE_CYCLES);
		// Clear partial window alarms so only channel 1 sets again
		pulse_alarm_clear();
		wait_window();
		check_flag("o_results[0].alarm_low", o_results[0].alarm_low, 1'b0);
		check_flag("o_results[0].alarm_high", o_results[0].alarm_high, 1'b0);
		check_flag("o_results[1].alarm_low", o_results[1].alarm_low, 1'b1);
		check_count(0, `CLKMON_GATE_CYCLES);
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin : main
		void'($urandom(RAND_SEED));
		i_sys_clk = 1'b0;
		i_reset = 1'b1;
		tst_clk0 = 1'b0;
		tst_clk1 = 1'b0;
		tst_run = 2'b11;
		i_ext_gate_en = 1'b0;
		i_ext_pps = 1'b0;
		i_alarm_clear = 1'b0;
		set_wide_limits();
		repeat (RESET_CYCLES) @(negedge i_sys_clk);
		i_reset = 1'b0;
		test_reset_state();
		test_internal_count();
		test_limit_alarms();
		test_external_gate();
		test_stopped_clock();
		if (error_count == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			end_with_failure();
		end
	end

endmodule

//--- flist.f
+incdir+hw
hw/clkmon_pkg.sv
hw/clkmon_gate_ctrl.sv
hw/clkmon_edge_sampler.sv
hw/clkmon_edge_counter.sv
hw/clkmon_range_check.sv
hw/clkmon_top.sv
verification/clkmon_asserts.sv
verification/clkmon_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the clock monitor testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module clkmon_tb -f flist.f -o clkmon_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/clkmon_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

echo "Simulation finished with status 0"
exit 0
